//--- include/aesSboxTables.svh
/*
 * AES S-box tables, forward and inverse
 * byte 0 of each table sits in the top eight bits
 */
`ifndef AES_SBOX_TABLES_SVH
`define AES_SBOX_TABLES_SVH

localparam logic [2047:0] SBOX_FWD = {
	128'h637c777bf26b6fc53001672bfed7ab76,
	128'hca82c97dfa5947f0add4a2af9ca472c0,
	128'hb7fd9326363ff7cc34a5e5f171d83115,
	128'h04c723c31896059a071280e2eb27b275,
	128'h09832c1a1b6e5aa0523bd6b329e32f84,
	128'h53d100ed20fcb15b6acbbe394a4c58cf,
	128'hd0efaafb434d338545f9027f503c9fa8,
	128'h51a3408f929d38f5bcb6da2110fff3d2,
	128'hcd0c13ec5f974417c4a77e3d645d1973,
	128'h60814fdc222a908846eeb814de5e0bdb,
	128'he0323a0a4906245cc2d3ac629195e479,
	128'he7c8376d8dd54ea96c56f4ea657aae08,
	128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
	128'h703eb5664803f60e613557b986c11d9e,
	128'he1f8981169d98e949b1e87e9ce5528df,
	128'h8ca1890dbfe6426841992d0fb054bb16
};

localparam logic [2047:0] SBOX_INV = {
	128'h52096ad53036a538bf40a39e81f3d7fb,
	128'h7ce339829b2fff87348e4344c4dee9cb,
	128'h547b9432a6c2233dee4c950b42fac34e,
	128'h082ea16628d924b2765ba2496d8bd125,
	128'h72f8f66486689816d4a45ccc5d65b692,
	128'h6c704850fdedb9da5e154657a78d9d84,
	128'h90d8ab008cbcd30af7e45805b8b34506,
	128'hd02c1e8fca3f0f02c1afbd0301138a6b,
	128'h3a9111414f67dcea97f2cfcef0b4e673,
	128'h96ac7422e7ad3585e2f937e81c75df6e,
	128'h47f11a711d29c5896fb7620eaa18be1b,
	128'hfc563e4bc6d279209adbc0fe78cd5af4,
	128'h1fdda8338807c731b11210592780ec5f,
	128'h60517fa919b54a0d2de57a9f93c99cef,
	128'ha0e03b4dae2af5b0c8ebbb3c83539961,
	128'h172b047eba77d626e169146355210c7d
};

`endif

//--- design/aesAlgoPkg.sv
/*
 * AES-128 algorithm package
 * constants, the state word and the byte-level helper functions
 */
package aesAlgoPkg;

	localparam int BLOCK_BITS = 128;
	localparam int BYTE_BITS = 8;
	localparam int NUM_ROUNDS = 10;
	localparam int ROUND_IDX_BITS = 4;

	// x^8 + x^4 + x^3 + x + 1 with the top bit dropped
	localparam logic [BYTE_BITS-1:0] GF_POLY_LOW = 8'h1b;

	`include "aesSboxTables.svh"

	// round constants for rounds 1 to 10, round 1 in the top byte
	localparam logic [NUM_ROUNDS*BYTE_BITS-1:0] RCON = 80'h01020408102040801b36;

	typedef logic [ROUND_IDX_BITS-1:0] roundIdx_t;

	localparam roundIdx_t LAST_ROUND = roundIdx_t'(NUM_ROUNDS);

	// byte 0 and column 0 are the leftmost, as in the FIPS-197 byte order
	typedef union packed {
		logic [0:15][BYTE_BITS-1:0] bytes;
		logic [0:3][4*BYTE_BITS-1:0] cols;
	} aesState_u;

	function automatic logic [BYTE_BITS-1:0] subByte(input logic [BYTE_BITS-1:0] b);
		return SBOX_FWD[BYTE_BITS * (2 ** BYTE_BITS - 1 - int'(b)) +: BYTE_BITS];
	endfunction

	function automatic logic [BYTE_BITS-1:0] invSubByte(input logic [BYTE_BITS-1:0] b);
		return SBOX_INV[BYTE_BITS * (2 ** BYTE_BITS - 1 - int'(b)) +: BYTE_BITS];
	endfunction

	// multiply by x in GF(2^8)
	function automatic logic [BYTE_BITS-1:0] gfDouble(input logic [BYTE_BITS-1:0] b);
		return {b[BYTE_BITS-2:0], 1'b0} ^ (b[BYTE_BITS-1] ? GF_POLY_LOW : '0);
	endfunction

	function automatic logic [4*BYTE_BITS-1:0] subWord(input logic [4*BYTE_BITS-1:0] w);
		logic [4*BYTE_BITS-1:0] res;
		for (int i = 0; i < 4; i++) begin
			res[BYTE_BITS*i +: BYTE_BITS] = subByte(w[BYTE_BITS*i +: BYTE_BITS]);
		end
		return res;
	endfunction

	// valid for rounds 1 to 10
	function automatic logic [BYTE_BITS-1:0] rconByte(input roundIdx_t r);
		return RCON[BYTE_BITS * (NUM_ROUNDS - int'(r)) +: BYTE_BITS];
	endfunction

endpackage

//--- design/cipherIfPkg.sv
/*
 * block cipher interface package
 * request, response and key-load words passed between the cipher blocks
 */
package cipherIfPkg;

	import aesAlgoPkg::*;

	// one block to process, its valid flag travels beside it
	typedef struct packed {
		logic [BLOCK_BITS-1:0] data;
		logic decrypt;
	} blockReq_s;

	typedef struct packed {
		logic [BLOCK_BITS-1:0] data;
	} blockRsp_s;

	// cipher key, always accepted when its valid is high
	typedef struct packed {
		logic [BLOCK_BITS-1:0] key;
	} keyLoad_s;

endpackage

//--- design/aesRoundFunc.sv
/*
 * AES round function, purely combinational
 * one encrypt or decrypt round, the last round skips column mixing
 */
`timescale 1ns/1ps

module aesRoundFunc
	import aesAlgoPkg::*;
(
	input aesState_u state,
	input aesState_u roundKey,
	input logic decrypt,
	input logic lastRound,
	output aesState_u nextState
);

	aesState_u encSub;
	aesState_u encShift;
	aesState_u encMix;
	aesState_u decShift;
	aesState_u decSub;
	aesState_u decKey;
	aesState_u decMix;

	// 2a0 ^ 3a1 ^ a2 ^ a3 rewritten as a0 ^ t ^ 2(a0 ^ a1), t being the column sum
	function automatic logic [31:0] mixColumn(input logic [31:0] col);
		logic [7:0] a0, a1, a2, a3, t;
		a0 = col[31:24];
		a1 = col[23:16];
		a2 = col[15:8];
		a3 = col[7:0];
		t = a0 ^ a1 ^ a2 ^ a3;
		return {a0 ^ t ^ gfDouble(a0 ^ a1), a1 ^ t ^ gfDouble(a1 ^ a2),
			a2 ^ t ^ gfDouble(a2 ^ a3), a3 ^ t ^ gfDouble(a3 ^ a0)};
	endfunction

	// folding 4(a0 ^ a2) and 4(a1 ^ a3) in first turns the forward mix into the inverse one
	function automatic logic [31:0] invMixPrep(input logic [31:0] col);
		logic [7:0] u, v;
		u = gfDouble(gfDouble(col[31:24] ^ col[15:8]));
		v = gfDouble(gfDouble(col[23:16] ^ col[7:0]));
		return col ^ {u, v, u, v};
	endfunction

	always_comb begin
		for (int i = 0; i < 16; i++) begin
			encSub.bytes[i] = subByte(state.bytes[i]);
		end
		// byte index is row + 4 * column, row r rotates left by r
		for (int r = 0; r < 4; r++) begin
			for (int c = 0; c < 4; c++) begin
				encShift.bytes[4*c + r] = encSub.bytes[4*((c + r) % 4) + r];
				decShift.bytes[4*c + r] = state.bytes[4*((c + 4 - r) % 4) + r];
			end
		end
		for (int i = 0; i < 16; i++) begin
			decSub.bytes[i] = invSubByte(decShift.bytes[i]);
		end
		decKey = decSub ^ roundKey;
		for (int c = 0; c < 4; c++) begin
			encMix.cols[c] = mixColumn(encShift.cols[c]);
			decMix.cols[c] = mixColumn(invMixPrep(decKey.cols[c]));
		end
	end

	always_comb begin
		if (decrypt) begin
			nextState = lastRound ? decKey : decMix;
		end else begin
			nextState = (lastRound ? encShift : encMix) ^ roundKey;
		end
	end

endmodule

//--- design/aesRoundEngine.sv
/*
 * iterative AES-128 engine
 * holds one block and applies one round per clock, ten clocks per block
 */
`timescale 1ns/1ps

module aesRoundEngine
	import aesAlgoPkg::*;
	import cipherIfPkg::*;
(
	input logic clk,
	input logic rst,
	input logic start,
	input blockReq_s req,
	input aesState_u roundKey,
	output roundIdx_t keyIdx,
	output logic done,
	output blockRsp_s rsp,
	output logic busy
);

	aesState_u state;
	aesState_u nextState;
	roundIdx_t rnd;
	logic dec;
	logic lastRound;

	assign lastRound = (rnd == LAST_ROUND);

	// when idle the key for the initial whitening is presented
	always_comb begin
		if (busy) begin
			keyIdx = dec ? LAST_ROUND - rnd : rnd;
		end else begin
			keyIdx = req.decrypt ? LAST_ROUND : '0;
		end
	end

	aesRoundFunc roundFunc (
		.state(state),
		.roundKey(roundKey),
		.decrypt(dec),
		.lastRound(lastRound),
		.nextState(nextState)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			done <= 1'b0;
			dec <= 1'b0;
			rnd <= '0;
		end else begin
			done <= busy && lastRound;
			if (start) begin
				busy <= 1'b1;
				dec <= req.decrypt;
				rnd <= roundIdx_t'(1);
			end else if (busy) begin
				if (lastRound) begin
					busy <= 1'b0;
				end else begin
					rnd <= rnd + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			state <= req.data ^ roundKey;
		end else if (busy) begin
			state <= nextState;
		end
	end

	assign rsp.data = state;

endmodule

//--- design/aesKeySchedule.sv
/*
 * AES-128 key expansion
 * builds the eleven round keys one per clock and keeps them for lookup
 */
`timescale 1ns/1ps

module aesKeySchedule
	import aesAlgoPkg::*;
	import cipherIfPkg::*;
(
	input logic clk,
	input logic rst,
	input logic load,
	input keyLoad_s key,
	input roundIdx_t keyIdx,
	output aesState_u roundKey,
	output logic keyReady
);

	aesState_u keyMem [0:NUM_ROUNDS];
	aesState_u prevKey;
	aesState_u nextKey;
	roundIdx_t genRnd;
	logic generating;
	logic [31:0] keyTemp;

	// RotWord then SubWord on the last column, plus the round constant
	assign keyTemp = subWord({prevKey.cols[3][23:0], prevKey.cols[3][31:24]}) ^
		{rconByte(genRnd), 24'h0};

	always_comb begin
		nextKey.cols[0] = prevKey.cols[0] ^ keyTemp;
		for (int c = 1; c < 4; c++) begin
			nextKey.cols[c] = prevKey.cols[c] ^ nextKey.cols[c-1];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			generating <= 1'b0;
			keyReady <= 1'b0;
			genRnd <= '0;
		end else if (load) begin
			generating <= 1'b1;
			keyReady <= 1'b0;
			genRnd <= roundIdx_t'(1);
		end else if (generating) begin
			if (genRnd == LAST_ROUND) begin
				generating <= 1'b0;
				keyReady <= 1'b1;
			end else begin
				genRnd <= genRnd + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			keyMem[0] <= key.key;
			prevKey <= key.key;
		end else if (generating) begin
			keyMem[genRnd] <= nextKey;
			prevKey <= nextKey;
		end
	end

	assign roundKey = keyMem[keyIdx];

endmodule

//--- design/aesCbcChain.sv
/*
 * CBC chaining around the round engine
 * whitens blocks in and out, tracks the chain value and gates requests
 */
`timescale 1ns/1ps

module aesCbcChain
	import aesAlgoPkg::*;
	import cipherIfPkg::*;
(
	input logic clk,
	input logic rst,
	input logic keyLoadValid,
	input logic keyReady,
	input logic reqValid,
	input blockReq_s req,
	input logic engBusy,
	input logic engDone,
	input blockRsp_s engRsp,
	output logic blockReady,
	output logic engStart,
	output blockReq_s engReq,
	output logic rspValid,
	output blockRsp_s rsp
);

	logic [BLOCK_BITS-1:0] chainVal;
	logic [BLOCK_BITS-1:0] chainNow;
	logic [BLOCK_BITS-1:0] outMask;
	logic curDecrypt;

	// a ciphertext finishing this cycle is already the chain value for a new block
	assign chainNow = (engDone && !curDecrypt) ? engRsp.data : chainVal;

	// a key load in the same cycle would change the keys under a new block
	assign blockReady = keyReady && !engBusy && !keyLoadValid;
	assign engStart = reqValid && blockReady;

	assign engReq.data = req.decrypt ? req.data : req.data ^ chainNow;
	assign engReq.decrypt = req.decrypt;

	always_ff @(posedge clk) begin
		if (rst) begin
			chainVal <= '0;
			curDecrypt <= 1'b0;
		end else begin
			if (keyLoadValid) begin
				chainVal <= '0;
			end else if (engStart && req.decrypt) begin
				chainVal <= req.data;
			end else begin
				chainVal <= chainNow;
			end
			if (engStart) begin
				curDecrypt <= req.decrypt;
			end
		end
	end

	// decryption XORs the previous ciphertext into the plain output
	always_ff @(posedge clk) begin
		if (engStart) begin
			outMask <= req.decrypt ? chainNow : '0;
		end
	end

	assign rspValid = engDone;
	assign rsp.data = engRsp.data ^ outMask;

endmodule

//--- design/aesCbcTop.sv
/*
 * AES-128 CBC cipher top level
 * key schedule, chaining logic and round engine
 */
`timescale 1ns/1ps

module aesCbcTop
	import aesAlgoPkg::*;
	import cipherIfPkg::*;
(
	input logic clk,
	input logic rst,
	input logic keyLoadValid,
	input keyLoad_s keyIn,
	input logic reqValid,
	input blockReq_s req,
	output logic blockReady,
	output logic rspValid,
	output blockRsp_s rsp,
	output logic keyReady
);

	roundIdx_t keyIdx;
	aesState_u roundKey;
	logic engStart;
	logic engBusy;
	logic engDone;
	blockReq_s engReq;
	blockRsp_s engRsp;

	aesKeySchedule keySchedule (
		.clk(clk),
		.rst(rst),
		.load(keyLoadValid),
		.key(keyIn),
		.keyIdx(keyIdx),
		.roundKey(roundKey),
		.keyReady(keyReady)
	);

	aesCbcChain chain (
		.clk(clk),
		.rst(rst),
		.keyLoadValid(keyLoadValid),
		.keyReady(keyReady),
		.reqValid(reqValid),
		.req(req),
		.engBusy(engBusy),
		.engDone(engDone),
		.engRsp(engRsp),
		.blockReady(blockReady),
		.engStart(engStart),
		.engReq(engReq),
		.rspValid(rspValid),
		.rsp(rsp)
	);

	aesRoundEngine engine (
		.clk(clk),
		.rst(rst),
		.start(engStart),
		.req(engReq),
		.roundKey(roundKey),
		.keyIdx(keyIdx),
		.done(engDone),
		.rsp(engRsp),
		.busy(engBusy)
	);

endmodule

//--- dv/aesCbc_sva.sv
/*
 * protocol assertions for the AES-128 CBC top level
 * result timing, ready gating, key schedule timing and reset state
 */
`timescale 1ns/1ps

module aesCbcSva (
	input logic clk,
	input logic rst,
	input logic keyLoadValid,
	input logic reqValid,
	input logic blockReady,
	input logic rspValid,
	input logic keyReady
);

	logic accept;
	logic [3:0] flightCnt;
	int failCount;

	assign accept = reqValid && blockReady;

	initial failCount = 0;

	// cycles left until the block accepted last shows up on rspValid
	always_ff @(posedge clk) begin
		if (rst) begin
			flightCnt <= '0;
		end else if (accept) begin
			flightCnt <= 4'd10;
		end else if (flightCnt != 4'd0) begin
			flightCnt <= flightCnt - 4'd1;
		end
	end

	rspAfterAccept: assert property (@(posedge clk) disable iff (rst)
		accept |-> ##11 rspValid)
		else begin
			failCount++;
			$error("rspValid did not follow an accepted request after ten edges");
		end

	rspFromAccept: assert property (@(posedge clk) disable iff (rst)
		rspValid |-> $past(accept, 11))
		else begin
			failCount++;
			$error("rspValid without a request accepted ten edges before");
		end

	rspOneCycle: assert property (@(posedge clk) disable iff (rst)
		rspValid |=> !rspValid)
		else begin
			failCount++;
			$error("rspValid stayed high for more than one cycle");
		end

	readyLowInFlight: assert property (@(posedge clk) disable iff (rst)
		flightCnt != 4'd0 |-> !blockReady)
		else begin
			failCount++;
			$error("blockReady high while a block is in flight");
		end

	readyWithRsp: assert property (@(posedge clk) disable iff (rst)
		rspValid && !keyLoadValid |-> blockReady)
		else begin
			failCount++;
			$error("blockReady low in the rspValid cycle");
		end

	keyReadyDrop: assert property (@(posedge clk) disable iff (rst)
		keyLoadValid |=> !keyReady)
		else begin
			failCount++;
			$error("keyReady did not drop after a key load");
		end

	keyReadyRise: assert property (@(posedge clk) disable iff (rst)
		keyLoadValid |-> ##11 keyReady)
		else begin
			failCount++;
			$error("keyReady not back ten edges after a key load");
		end

	keyReadyEarly: assert property (@(posedge clk) disable iff (rst)
		$rose(keyReady) |-> $past(keyLoadValid, 11))
		else begin
			failCount++;
			$error("keyReady rose at the wrong time after a key load");
		end

	quietAfterReset: assert property (@(posedge clk)
		$past(rst) |-> !rspValid && !keyReady && !blockReady)
		else begin
			failCount++;
			$error("outputs not quiet after reset");
		end

endmodule

bind aesCbcTop aesCbcSva protocolChecks (
	.clk(clk),
	.rst(rst),
	.keyLoadValid(keyLoadValid),
	.reqValid(reqValid),
	.blockReady(blockReady),
	.rspValid(rspValid),
	.keyReady(keyReady)
);

//--- dv/aesCbcTb.sv
/*
 * testbench for the AES-128 CBC cipher
 * known answers, a CBC round trip, chaining and dropped requests
 */
`timescale 1ns/1ps

module aesCbcTb
	import cipherIfPkg::*;
();

	localparam int CLK_PERIOD = 100;
	localparam int NUM_KEY_LOADS = 6;
	localparam int NUM_CHAIN_BLOCKS = 8;
	localparam int NUM_BLOCKS = 2 * NUM_CHAIN_BLOCKS + 5;
	localparam int WATCHDOG_NS = 2 * (NUM_KEY_LOADS + NUM_BLOCKS) * 12 * CLK_PERIOD;
	localparam int JUNK_CYCLES = 6;

	// FIPS-197 appendix C.1
	localparam logic [127:0] FIPS_KEY = 128'h000102030405060708090a0b0c0d0e0f;
	localparam logic [127:0] FIPS_PT = 128'h00112233445566778899aabbccddeeff;
	localparam logic [127:0] FIPS_CT = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

	logic clk;
	logic rst;
	logic keyLoadValid;
	keyLoad_s keyIn;
	logic reqValid;
	blockReq_s req;
	logic blockReady;
	logic rspValid;
	blockRsp_s rsp;
	logic keyReady;

	integer seed;
	int errorCount;
	int acceptCount;
	int rspCount;
	logic [127:0] plainText [NUM_CHAIN_BLOCKS];
	logic [127:0] cipherText [NUM_CHAIN_BLOCKS];

	aesCbcTop dut (
		.clk(clk),
		.rst(rst),
		.keyLoadValid(keyLoadValid),
		.keyIn(keyIn),
		.reqValid(reqValid),
		.req(req),
		.blockReady(blockReady),
		.rspValid(rspValid),
		.rsp(rsp),
		.keyReady(keyReady)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// acceptance happens at the rising edge, results are counted mid-cycle
	always @(posedge clk) begin
		if (!rst && reqValid && blockReady) begin
			acceptCount++;
		end
	end

	always @(negedge clk) begin
		if (!rst && rspValid) begin
			rspCount++;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout after %0d ns, the DUT stopped responding", WATCHDOG_NS);
		$display("*** TEST FAILED ***");
		$finish;
	end

	task automatic loadKey(input logic [127:0] key);
		keyLoadValid = 1'b1;
		keyIn.key = key;
		@(negedge clk);
		keyLoadValid = 1'b0;
		while (!keyReady) begin
			@(negedge clk);
		end
	endtask

	// junkCycles extra requests are issued while the block is in flight
	task automatic runBlock(input logic [127:0] data, input logic decrypt,
		input int junkCycles, output logic [127:0] result);
		while (!blockReady) begin
			@(negedge clk);
		end
		reqValid = 1'b1;
		req.data = data;
		req.decrypt = decrypt;
		@(negedge clk);
		for (int i = 0; i < junkCycles; i++) begin
			assert (!blockReady) else begin
				errorCount++;
				$display("[ERROR] blockReady: got %h, expected %h", blockReady, 1'b0);
			end
			req.data = {$random(seed), $random(seed), $random(seed), $random(seed)};
			req.decrypt = 1'b0;
			@(negedge clk);
		end
		reqValid = 1'b0;
		while (!rspValid) begin
			@(negedge clk);
		end
		result = rsp.data;
	endtask

	task automatic checkBlock(input string label, input logic [127:0] got,
		input logic [127:0] exp);
		assert (got === exp) else begin
			errorCount++;
			$display("[ERROR] rsp.data (%s): got %h, expected %h", label, got, exp);
		end
	endtask

	initial begin
		logic [127:0] result;
		logic [127:0] chainKey;
		logic [127:0] firstCt;
		logic [127:0] secondCt;
		int rspBefore;
		int svaFails;

		clk = 1'b0;
		rst = 1'b1;
		keyLoadValid = 1'b0;
		keyIn = '0;
		reqValid = 1'b0;
		req = '0;
		seed = 32'hbb99;
		errorCount = 0;
		acceptCount = 0;
		rspCount = 0;
		repeat (2) @(negedge clk);
		rst = 1'b0;

		// a fresh chain starts from zero, so the first block is plain ECB
		loadKey(FIPS_KEY);
		runBlock(FIPS_PT, 1'b0, 0, result);
		checkBlock("encrypt known answer", result, FIPS_CT);

		loadKey(FIPS_KEY);
		runBlock(FIPS_CT, 1'b1, 0, result);
		checkBlock("decrypt known answer", result, FIPS_PT);

		chainKey = {$random(seed), $random(seed), $random(seed), $random(seed)};
		loadKey(chainKey);
		for (int i = 0; i < NUM_CHAIN_BLOCKS; i++) begin
			plainText[i] = {$random(seed), $random(seed), $random(seed), $random(seed)};
			runBlock(plainText[i], 1'b0, 0, result);
			cipherText[i] = result;
		end
		loadKey(chainKey);
		for (int i = 0; i < NUM_CHAIN_BLOCKS; i++) begin
			runBlock(cipherText[i], 1'b1, 0, result);
			checkBlock("CBC round trip", result, plainText[i]);
		end

		loadKey(FIPS_KEY);
		runBlock(FIPS_PT, 1'b0, 0, firstCt);
		runBlock(FIPS_PT, 1'b0, 0, secondCt);
		checkBlock("first block of a chain", firstCt, FIPS_CT);
		assert (secondCt !== firstCt) else begin
			errorCount++;
			$display("the same plaintext twice in a chain gave the same ciphertext twice");
		end

		// the extra requests hit a busy DUT and must leave no trace
		loadKey(FIPS_KEY);
		rspBefore = rspCount;
		runBlock(FIPS_PT, 1'b0, JUNK_CYCLES, result);
		checkBlock("block with dropped requests", result, FIPS_CT);
		repeat (15) @(negedge clk);
		assert (rspCount - rspBefore == 1) else begin
			errorCount++;
			$display("[ERROR] rspCount: got %h, expected %h", rspCount, rspBefore + 1);
		end
		assert (rspCount == acceptCount) else begin
			errorCount++;
			$display("[ERROR] rspCount: got %h, expected %h", rspCount, acceptCount);
		end

		svaFails = dut.protocolChecks.failCount;
		$display("failed checks: %0d, assertion failures: %0d, accepted: %0d, responses: %0d",
			errorCount, svaFails, acceptCount, rspCount);
		if (errorCount == 0 && svaFails == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

//--- aesCipher.f
+incdir+include
design/aesAlgoPkg.sv
design/cipherIfPkg.sv
design/aesRoundFunc.sv
design/aesRoundEngine.sv
design/aesKeySchedule.sv
design/aesCbcChain.sv
design/aesCbcTop.sv
dv/aesCbc_sva.sv
dv/aesCbcTb.sv

//--- run.sh
#!/bin/sh
# build the AES CBC testbench with Verilator, run it and scan the log

LOG=sim.log

rm -rf obj_dir "$LOG"

verilator --binary --timing --assert --top-module aesCbcTb -f aesCipher.f \
	&& ./obj_dir/VaesCbcTb +verilator+error+limit+1000 > "$LOG" 2>&1 \
	|| { cat "$LOG" 2>/dev/null; echo "build or simulation run did not complete"; exit 1; }

cat "$LOG"

grep -qF '*** TEST FAILED ***' "$LOG" \
	&& { echo "simulation reported a failure"; exit 1; }

echo "simulation finished without a reported failure"
exit 0
